/* regFilePkg.sv */
// Shared sizes and types for the banked register file
// The indexer bit split only holds when warp and register index widths
// add up to bank select plus in-bank address widths
// All widths derive from the counts below, keep them powers of two

package regFilePkg;

    // ##################################################
    // Sizes
    // ##################################################

    // Warps per compute unit
    localparam int unsigned NumWarps = 8;
    // Register banks, each single read and single write
    localparam int unsigned NumBanks = 4;
    // Entries in one bank
    localparam int unsigned RegistersPerBank = 128;
    // Registers addressable by one warp
    localparam int unsigned RegIdxWidth = 6;
    // Register width
    localparam int unsigned DataWidth = 32;

    // Derived widths
    localparam int unsigned WidWidth = $clog2(NumWarps);
    localparam int unsigned BankSelWidth = $clog2(NumBanks);
    localparam int unsigned BankRegAddrWidth = $clog2(RegistersPerBank);

    // ##################################################
    // Types
    // ##################################################

    typedef logic [WidWidth-1:0] widT;
    typedef logic [RegIdxWidth-1:0] regIdxT;
    typedef logic [BankSelWidth-1:0] bankSelT;
    typedef logic [BankRegAddrWidth-1:0] bankRegAddrT;
    typedef logic [DataWidth-1:0] regDataT;

    // Arbiter states
    // ArbServeB holds the deferred read of path B after a bank conflict
    typedef enum logic [0:0] {
        ArbIdle,
        ArbServeB
    } arbStateT;

endpackage

/* registerIndexer.sv */
// Maps a warp id and register index onto a bank and an in-bank address
// Purely combinational, no clock
// Each warp keeps its registers in one bank, two warps share a bank

`timescale 1ns/1ns

module registerIndexer
    import regFilePkg::*;
(
    // Request side
    input  widT         wid,
    input  regIdxT      regIdx,

    // Bank side
    output bankSelT     bankSel,
    output bankRegAddrT bankRegAddr
);

    // Flat register number across the whole compute unit
    logic [WidWidth+RegIdxWidth-1:0] flatIdx;

    // ##################################################
    // Split
    // ##################################################

    // Warp id sits above the register index
    assign flatIdx = {wid, regIdx};

    // Top bits pick the bank
    // Upper warp id bits land here, so warps pair up per bank
    assign bankSel = flatIdx[WidWidth+RegIdxWidth-1:BankRegAddrWidth];

    // Remaining bits address the entry inside that bank
    assign bankRegAddr = flatIdx[BankRegAddrWidth-1:0];

    // ##################################################
    // Checks
    // ##################################################

    // Both sides of the split must cover the same number of bits
    initial begin
        assert (WidWidth + RegIdxWidth == BankSelWidth + BankRegAddrWidth)
            else $error("registerIndexer: wid+regIdx width differs from bankSel+bankRegAddr");
    end

endmodule

/* registerBank.sv */
// One register bank with a single write port and a single read port
// Read data appears one cycle after the address, read port always enabled
// No reset, contents are undefined until written
// Same-cycle read and write of one address returns the old contents

`timescale 1ns/1ns

module registerBank
    import regFilePkg::*;
(
    input  logic        clk,

    // Write port
    input  logic        writeEn,
    input  bankRegAddrT writeAddr,
    input  regDataT     writeData,

    // Read port
    input  bankRegAddrT readAddr,
    output regDataT     readData
);

    // Storage array
    regDataT mem [RegistersPerBank];

    // ##################################################
    // Write
    // ##################################################

    always_ff @(posedge clk) begin
        if (writeEn) begin
            mem[writeAddr] <= writeData;
        end
    end

    // ##################################################
    // Read
    // ##################################################

    // Registered read
    // The array is sampled before this edge's write lands, so old data wins
    always_ff @(posedge clk) begin
        readData <= mem[readAddr];
    end

endmodule

/* bankReadArbiter.sv */
// Merges operand read paths A and B onto the register banks
// Requests are single-cycle strobes, no handshake, results are strobes too
// Same bank with different addresses serializes B by one cycle, busy is
// high during that cycle and any request offered then is dropped

`timescale 1ns/1ns

module bankReadArbiter
    import regFilePkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // Path A request
    input  logic        reqValidA,
    input  bankSelT     bankSelA,
    input  bankRegAddrT bankAddrA,

    // Path B request
    input  logic        reqValidB,
    input  bankSelT     bankSelB,
    input  bankRegAddrT bankAddrB,

    // Bank side
    output bankRegAddrT bankReadAddr [NumBanks],
    input  regDataT     bankReadData [NumBanks],

    // Operand return
    output logic        dataValidA,
    output logic        dataValidB,
    output regDataT     dataA,
    output regDataT     dataB,
    output logic        busy
);

    arbStateT    state;

    // Request decode
    logic        acceptA;
    logic        acceptB;
    logic        sameBank;
    logic        sameAddr;
    logic        conflict;

    // Reads in flight, returned next cycle
    logic        pendA;
    logic        pendB;
    bankSelT     pendBankA;
    bankSelT     pendBankB;

    // Deferred path B request
    bankSelT     heldBankB;
    bankRegAddrT heldAddrB;

    // ##################################################
    // Request decode
    // ##################################################

    assign busy = (state == ArbServeB);

    // Nothing is taken while B's deferred read goes out
    assign acceptA = reqValidA && !busy;
    assign acceptB = reqValidB && !busy;

    assign sameBank = (bankSelA == bankSelB);
    assign sameAddr = (bankAddrA == bankAddrB);

    // Two different entries in one bank need two cycles
    assign conflict = acceptA && acceptB && sameBank && !sameAddr;

    // Per-bank read address steering
    always_comb begin
        for (int b = 0; b < NumBanks; b++) begin
            bankReadAddr[b] = '0;
            if (busy) begin
                // Only the deferred B read is issued
                if (heldBankB == bankSelT'(b)) begin
                    bankReadAddr[b] = heldAddrB;
                end
            end else begin
                if (acceptB && bankSelB == bankSelT'(b)) begin
                    bankReadAddr[b] = bankAddrB;
                end
                // A wins its bank, B gets it next cycle on a conflict
                if (acceptA && bankSelA == bankSelT'(b)) begin
                    bankReadAddr[b] = bankAddrA;
                end
            end
        end
    end

    // ##################################################
    // Control state
    // ##################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ArbIdle;
            pendA      <= 1'b0;
            pendB      <= 1'b0;
        end else begin
            pendA      <= acceptA;
            case (state)
                ArbIdle: begin
                    // B returns now unless it lost its bank to A
                    pendB <= acceptB && !conflict;
                    if (conflict) begin
                        state <= ArbServeB;
                    end
                end
                ArbServeB: begin
                    // Deferred read was issued this cycle
                    pendB <= 1'b1;
                    state <= ArbIdle;
                end
                default: begin
                    pendB <= 1'b0;
                    state <= ArbIdle;
                end
            endcase
        end
    end

    // Bank tags and the held request, no reset needed
    always_ff @(posedge clk) begin
        if (acceptA) begin
            pendBankA <= bankSelA;
        end
        if (busy) begin
            pendBankB <= heldBankB;
        end else if (acceptB) begin
            pendBankB <= bankSelB;
        end
        if (conflict) begin
            heldBankB <= bankSelB;
            heldAddrB <= bankAddrB;
        end
    end

    // ##################################################
    // Operand return
    // ##################################################

    assign dataValidA = pendA;
    assign dataValidB = pendB;

    assign dataA = bankReadData[pendBankA];

    // Identical register on both paths shares one read, B's tag names that bank
    assign dataB = bankReadData[pendBankB];

    // ##################################################
    // Assertions
    // ##################################################

    // Serialization costs exactly one extra cycle
    busyOneCycle: assert property (@(posedge clk) disable iff (rst)
        busy |=> !busy)
        else $error("bankReadArbiter: busy held for two cycles");

    // Deferred B must not come back together with A
    noEarlyB: assert property (@(posedge clk) disable iff (rst)
        conflict |=> !dataValidB)
        else $error("bankReadArbiter: dataValidB right after a conflict");

    // Strobes only ever answer an accepted or deferred request
    noSpuriousStrobe: assert property (@(posedge clk) disable iff (rst)
        (!busy && !acceptA && !acceptB) |=> !(dataValidA || dataValidB))
        else $error("bankReadArbiter: strobe without a request");

endmodule

/* registerFileTop.sv */
// Banked register file of one compute unit, 8 warps x 64 registers x 32 bits
// Two operand read paths and one write port, all plain strobes
// Operands return one cycle after the request, two for a deferred B
// Requests offered while busy is high are dropped

`timescale 1ns/1ns

module registerFileTop
    import regFilePkg::*;
(
    input  logic    clk,
    input  logic    rst,

    // Read path A
    input  logic    readValidA,
    input  widT     readWidA,
    input  regIdxT  readRegIdxA,

    // Read path B
    input  logic    readValidB,
    input  widT     readWidB,
    input  regIdxT  readRegIdxB,

    // Write port
    input  logic    writeEn,
    input  widT     writeWid,
    input  regIdxT  writeRegIdx,
    input  regDataT writeData,

    // Operands
    output logic    dataValidA,
    output regDataT dataA,
    output logic    dataValidB,
    output regDataT dataB,
    output logic    busy
);

    // Indexed requests
    bankSelT     bankSelA;
    bankRegAddrT bankAddrA;
    bankSelT     bankSelB;
    bankRegAddrT bankAddrB;
    bankSelT     writeBankSel;
    bankRegAddrT writeBankAddr;

    // Bank ports
    logic [NumBanks-1:0] bankWriteEn;
    bankRegAddrT bankReadAddr [NumBanks];
    regDataT     bankReadData [NumBanks];

    // ##################################################
    // Indexers
    // ##################################################

    registerIndexer indexerA (
        .wid         (readWidA),
        .regIdx      (readRegIdxA),
        .bankSel     (bankSelA),
        .bankRegAddr (bankAddrA)
    );

    registerIndexer indexerB (
        .wid         (readWidB),
        .regIdx      (readRegIdxB),
        .bankSel     (bankSelB),
        .bankRegAddr (bankAddrB)
    );

    registerIndexer indexerWrite (
        .wid         (writeWid),
        .regIdx      (writeRegIdx),
        .bankSel     (writeBankSel),
        .bankRegAddr (writeBankAddr)
    );

    // ##################################################
    // Banks
    // ##################################################

    for (genvar b = 0; b < NumBanks; b++) begin : gBank
        // Write goes only to the bank its warp lives in
        assign bankWriteEn[b] = writeEn && (writeBankSel == bankSelT'(b));

        registerBank bank (
            .clk       (clk),
            .writeEn   (bankWriteEn[b]),
            .writeAddr (writeBankAddr),
            .writeData (writeData),
            .readAddr  (bankReadAddr[b]),
            .readData  (bankReadData[b])
        );
    end

    // Read arbitration and operand return
    bankReadArbiter arbiter (
        .clk          (clk),
        .rst          (rst),
        .reqValidA    (readValidA),
        .bankSelA     (bankSelA),
        .bankAddrA    (bankAddrA),
        .reqValidB    (readValidB),
        .bankSelB     (bankSelB),
        .bankAddrB    (bankAddrB),
        .bankReadAddr (bankReadAddr),
        .bankReadData (bankReadData),
        .dataValidA   (dataValidA),
        .dataValidB   (dataValidB),
        .dataA        (dataA),
        .dataB        (dataB),
        .busy         (busy)
    );

endmodule

/* tbChecker.sv */
// Scoreboard for the banked register file, samples on the falling edge
// Keeps a shadow copy of all 512 registers, built from observed writes
// Expects operands one cycle after acceptance, deferred B one cycle later

`timescale 1ns/1ns

module tbChecker
    import regFilePkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    readValidA,
    input  widT     readWidA,
    input  regIdxT  readRegIdxA,
    input  logic    readValidB,
    input  widT     readWidB,
    input  regIdxT  readRegIdxB,
    input  logic    writeEn,
    input  widT     writeWid,
    input  regIdxT  writeRegIdx,
    input  regDataT writeData,
    input  logic    dataValidA,
    input  regDataT dataA,
    input  logic    dataValidB,
    input  regDataT dataB,
    input  logic    busy,
    output int      errorCount,
    output int      pendingCount
);

    // Shadow of every register, indexed by {wid, regIdx}
    regDataT shadow [NumWarps << RegIdxWidth];

    // Expected operands and the cycle each one is due
    regDataT expA [$];
    int      dueA [$];
    regDataT expB [$];
    int      dueB [$];

    int      cyc;
    int      flatA;
    int      flatB;
    logic    expBusy;
    logic    busyNow;
    logic    conflict;
    // B read put off by a bank conflict
    logic    deferValid;
    int      deferIdx;

    task automatic compareData(input string sig, input regDataT expected,
                               input regDataT actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, got %h", sig, expected, actual);
            errorCount++;
        end
    endtask

    // ##################################################
    // Per-cycle model
    // ##################################################

    always @(negedge clk) begin
        if (rst) begin
            expA.delete();
            dueA.delete();
            expB.delete();
            dueB.delete();
            cyc = 0;
            expBusy = 1'b0;
            deferValid = 1'b0;
            errorCount = 0;
            pendingCount = 0;
        end else begin
            cyc++;

            // Operands that should have arrived by now
            if (dueA.size() > 0 && dueA[0] < cyc) begin
                $display("Error: read on path A got no operand strobe (cycle %0d)", cyc);
                void'(expA.pop_front());
                void'(dueA.pop_front());
                errorCount++;
            end
            if (dueB.size() > 0 && dueB[0] < cyc) begin
                $display("Error: read on path B got no operand strobe (cycle %0d)", cyc);
                void'(expB.pop_front());
                void'(dueB.pop_front());
                errorCount++;
            end

            // Strobes against the queues
            if (dataValidA) begin
                if (dueA.size() == 0 || dueA[0] != cyc) begin
                    $display("Error: dataValidA pulsed with no pending read (cycle %0d)", cyc);
                    errorCount++;
                end else begin
                    compareData("dataA", expA.pop_front(), dataA);
                    void'(dueA.pop_front());
                end
            end
            if (dataValidB) begin
                if (dueB.size() == 0 || dueB[0] != cyc) begin
                    $display("Error: dataValidB pulsed with no pending read (cycle %0d)", cyc);
                    errorCount++;
                end else begin
                    compareData("dataB", expB.pop_front(), dataB);
                    void'(dueB.pop_front());
                end
            end

            if (busy !== expBusy) begin
                $display("FAIL busy: expected %h, got %h", expBusy, busy);
                errorCount++;
            end

            // Deferred B read goes out now, ahead of this cycle's write
            if (deferValid) begin
                expB.push_back(shadow[deferIdx]);
                dueB.push_back(cyc + 1);
                deferValid = 1'b0;
            end

            // New requests, dropped while busy
            busyNow = expBusy;
            expBusy = 1'b0;
            if (!busyNow) begin
                flatA = int'({readWidA, readRegIdxA});
                flatB = int'({readWidB, readRegIdxB});
                // Same bank means same upper two bits of the flat number
                conflict = readValidA && readValidB && flatA != flatB
                    && (flatA / RegistersPerBank) == (flatB / RegistersPerBank);
                if (readValidA) begin
                    expA.push_back(shadow[flatA]);
                    dueA.push_back(cyc + 1);
                end
                if (readValidB && conflict) begin
                    deferValid = 1'b1;
                    deferIdx = flatB;
                    expBusy = 1'b1;
                end else if (readValidB) begin
                    expB.push_back(shadow[flatB]);
                    dueB.push_back(cyc + 1);
                end
            end

            // Write lands after the reads of this cycle saw the old value
            if (writeEn) begin
                shadow[int'({writeWid, writeRegIdx})] = writeData;
            end

            pendingCount = expA.size() + expB.size() + int'(deferValid);
        end
    end

endmodule

/* tbRegisterFile.sv */
// Testbench top for the banked register file
// A table of entries is applied one per clock, checks live in tbChecker
// Read entries marked to wait are held until they meet a cycle with busy low
// The random part of the table comes from an LCG with a fixed seed

`timescale 1ns/1ns

module tbRegisterFile
    import regFilePkg::*;
();

    // Wait limits in clock cycles
    localparam int BusyTimeout = 8;
    localparam int DrainTimeout = 32;
    localparam int RandomEntries = 200;
    localparam int NumRegs = 1 << RegIdxWidth;

    logic    clk;
    logic    rst;
    logic    readValidA;
    widT     readWidA;
    regIdxT  readRegIdxA;
    logic    readValidB;
    widT     readWidB;
    regIdxT  readRegIdxB;
    logic    writeEn;
    widT     writeWid;
    regIdxT  writeRegIdx;
    regDataT writeData;
    logic    dataValidA;
    regDataT dataA;
    logic    dataValidB;
    regDataT dataB;
    logic    busy;

    int      errorCount;
    int      pendingCount;
    int      timeouts;
    int unsigned lcgState;

    // ##################################################
    // Stimulus table, one column per field
    // ##################################################

    logic    tWr [$];
    widT     tWWid [$];
    regIdxT  tWIdx [$];
    regDataT tWData [$];
    logic    tRdA [$];
    widT     tWidA [$];
    regIdxT  tIdxA [$];
    logic    tRdB [$];
    widT     tWidB [$];
    regIdxT  tIdxB [$];
    logic    tWait [$];

    // Distinct value for every register, odd multiplier keeps it one to one
    function automatic regDataT fillPattern(input widT w, input regIdxT r);
        return (regDataT'({w, r}) * 32'h9E3779B1) ^ 32'hC0DE0000;
    endfunction

    function automatic int unsigned lcgNext();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState ^ (lcgState >> 15);
    endfunction

    task automatic addEntry(input logic wr, input widT wWid, input regIdxT wIdx,
                            input regDataT wData, input logic rdA, input widT widA,
                            input regIdxT idxA, input logic rdB, input widT widB,
                            input regIdxT idxB, input logic waitIdle);
        tWr.push_back(wr);
        tWWid.push_back(wWid);
        tWIdx.push_back(wIdx);
        tWData.push_back(wData);
        tRdA.push_back(rdA);
        tWidA.push_back(widA);
        tIdxA.push_back(idxA);
        tRdB.push_back(rdB);
        tWidB.push_back(widB);
        tIdxB.push_back(idxB);
        tWait.push_back(waitIdle);
    endtask

    task automatic addIdle();
        addEntry(1'b0, '0, '0, '0, 1'b0, '0, '0, 1'b0, '0, '0, 1'b0);
    endtask

    task automatic addWrite(input widT w, input regIdxT r, input regDataT d);
        addEntry(1'b1, w, r, d, 1'b0, '0, '0, 1'b0, '0, '0, 1'b0);
    endtask

    task automatic addRead(input logic rdA, input widT widA, input regIdxT idxA,
                           input logic rdB, input widT widB, input regIdxT idxB,
                           input logic waitIdle);
        addEntry(1'b0, '0, '0, '0, rdA, widA, idxA, rdB, widB, idxB, waitIdle);
    endtask

    task automatic buildTable();
        int unsigned r;
        widT    wa;
        widT    wb;
        widT    ww;
        regIdxT ia;
        regIdxT ib;
        regIdxT iw;
        // Quiet stretch, no strobes and no busy expected
        for (int n = 0; n < 20; n++) begin
            addIdle();
        end
        // Fill all warps and registers, then read back on both paths
        for (int w = 0; w < NumWarps; w++) begin
            for (int x = 0; x < NumRegs; x++) begin
                addWrite(widT'(w), regIdxT'(x), fillPattern(widT'(w), regIdxT'(x)));
            end
        end
        // Warp w and w^4 always sit in different banks
        for (int w = 0; w < NumWarps; w++) begin
            for (int x = 0; x < NumRegs; x++) begin
                addRead(1'b1, widT'(w), regIdxT'(x), 1'b1, widT'(w ^ 4), regIdxT'(x), 1'b1);
            end
        end
        // Different banks, both at N+1
        addRead(1'b1, 3'd0, 6'd5, 1'b1, 3'd4, 6'd9, 1'b1);
        // Warps 2 and 3 share bank 1, then a request offered during busy
        addRead(1'b1, 3'd2, 6'd1, 1'b1, 3'd3, 6'd7, 1'b1);
        addRead(1'b1, 3'd0, 6'd0, 1'b1, 3'd1, 6'd2, 1'b0);
        addIdle();
        addIdle();
        // Same register on both paths
        addRead(1'b1, 3'd5, 6'd33, 1'b1, 3'd5, 6'd33, 1'b1);
        // Read in the write cycle sees the old value, the next one the new
        addEntry(1'b1, 3'd6, 6'd12, 32'hFEEDF00D, 1'b1, 3'd6, 6'd12, 1'b0, '0, '0, 1'b1);
        addRead(1'b1, 3'd6, 6'd12, 1'b0, '0, '0, 1'b1);
        // Random mix
        for (int n = 0; n < RandomEntries; n++) begin
            r = lcgNext();
            wa = widT'(lcgNext());
            wb = widT'(lcgNext());
            ww = widT'(lcgNext());
            ia = regIdxT'(lcgNext());
            ib = regIdxT'(lcgNext());
            iw = regIdxT'(lcgNext());
            case (r % 5)
                0: addIdle();
                1: addWrite(ww, iw, regDataT'(lcgNext()));
                2: addRead(1'b1, wa, ia, r[8], wb, ib, 1'b1);
                3: addEntry(1'b1, ww, iw, regDataT'(lcgNext()), 1'b1, wa, ia,
                            1'b1, wb, ib, 1'b1);
                // Neighbour warp shares the bank, a sure conflict
                default: addRead(1'b1, wa, ia, 1'b1, wa ^ 3'd1, ib, 1'b1);
            endcase
        end
    endtask

    task automatic driveEntry(input int i);
        writeEn     <= tWr[i];
        writeWid    <= tWWid[i];
        writeRegIdx <= tWIdx[i];
        writeData   <= tWData[i];
        readValidA  <= tRdA[i];
        readWidA    <= tWidA[i];
        readRegIdxA <= tIdxA[i];
        readValidB  <= tRdB[i];
        readWidB    <= tWidB[i];
        readRegIdxB <= tIdxB[i];
    endtask

    // ##################################################
    // Clock, DUT and checker
    // ##################################################

    always #5 clk = ~clk;

    registerFileTop UUT (.*);

    tbChecker respCheck (.*);

    initial begin
        int holdCycles;
        int drainCycles;
        clk = 1'b0;
        rst = 1'b1;
        readValidA = 1'b0;
        readWidA = '0;
        readRegIdxA = '0;
        readValidB = 1'b0;
        readWidB = '0;
        readRegIdxB = '0;
        writeEn = 1'b0;
        writeWid = '0;
        writeRegIdx = '0;
        writeData = '0;
        timeouts = 0;
        lcgState = 32'd8816;
        buildTable();

        repeat (16) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < tWr.size(); i++) begin
            @(posedge clk);
            driveEntry(i);
            if ((tRdA[i] || tRdB[i]) && tWait[i]) begin
                // Busy seen here decides whether the next edge drops the read
                holdCycles = 0;
                @(negedge clk);
                while (busy && holdCycles < BusyTimeout) begin
                    @(posedge clk);
                    writeEn <= 1'b0;
                    @(negedge clk);
                    holdCycles++;
                end
                if (busy) begin
                    $display("Timeout: busy stayed high at table entry %0d", i);
                    timeouts++;
                end
            end
        end

        // Back to idle, then let the last operands come back
        @(posedge clk);
        readValidA <= 1'b0;
        readValidB <= 1'b0;
        writeEn <= 1'b0;
        drainCycles = 0;
        @(posedge clk);
        while (pendingCount != 0 && drainCycles < DrainTimeout) begin
            @(posedge clk);
            drainCycles++;
        end
        if (pendingCount != 0) begin
            $display("Timeout: %0d reads still without an operand", pendingCount);
            timeouts++;
        end

        $display("Check errors: %0d, timeouts: %0d", errorCount, timeouts);
        if (errorCount == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
regFilePkg.sv
registerIndexer.sv
registerBank.sv
bankReadArbiter.sv
registerFileTop.sv
tbChecker.sv
tbRegisterFile.sv

/* Makefile */
# Verilator build and run for the banked register file testbench

VERILATOR := verilator
VFLAGS    := --binary --assert --timing -Wno-fatal
TOP       := tbRegisterFile
FILELIST  := build.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
